// File: common/atg_regs_pkg.sv
package atg_regs_pkg;

  // bus and pointer widths
  localparam int REG_DATA_W = 32;
  localparam int REG_COUNT  = 16;
  localparam int PTR_W      = 10;

  typedef logic [REG_DATA_W-1:0]   reg_word_t;
  typedef logic [REG_COUNT-1:0]    reg_sel_t;
  typedef logic [PTR_W-1:0]        cmd_ptr_t;
  typedef logic [REG_DATA_W/2-1:0] err_half_t;

  // run state machine where ACTIVE is the run enable
  typedef enum logic {
    RUN_IDLE,
    RUN_ACTIVE
  } run_state_t;

  // register decode lines
  localparam int REG_CTRL    = 0;
  localparam int REG_SLV_CTL = 1;
  localparam int REG_ERR_STS = 2;
  localparam int REG_ERR_EN  = 3;
  localparam int REG_MST_CTL = 4;
  localparam int REG_CONFIG  = 5;

  // field positions
  localparam int CTRL_ENABLE_BIT = 20;
  localparam int CTRL_LOOP_BIT   = 19;
  localparam int ERRSIG_EN_BIT   = 15;
  // run complete in status also drives the interrupt
  localparam int DONE_ERR_BIT    = 31;

  localparam logic [7:0] ATG_REV      = 8'h20;
  localparam reg_word_t  ERR_EN_RESET = 32'h8000_0000;
  localparam reg_word_t  SLV_CTL_MASK = 32'h000F_FFFF;
  localparam reg_word_t  MST_CTL_MASK = 32'h0000_FFFF;

endpackage

// File: control/atg_run_ctl.sv
`timescale 1ns/1ps

module atg_run_ctl #(
  parameter int HLTP_REPEAT = 0
) (
  input  logic                    Clk,
  input  logic                    rst_l,
  input  atg_regs_pkg::reg_sel_t  wr_reg_decode,
  input  atg_regs_pkg::reg_word_t wr_reg_data,
  input  logic                    core_global_start,
  input  logic                    core_global_stop,
  input  logic                    mr_done,
  input  logic                    mw_done,
  input  atg_regs_pkg::cmd_ptr_t  mr_ptr_update,
  input  atg_regs_pkg::cmd_ptr_t  mw_ptr_update,
  output logic                    run_start,
  output logic                    run_done,
  output logic                    run_enable,
  output logic                    run_enable_late,
  output logic                    loop_enable,
  output atg_regs_pkg::cmd_ptr_t  mr_ptr,
  output atg_regs_pkg::cmd_ptr_t  mw_ptr
);
  import atg_regs_pkg::*;

  logic       start_q;
  logic       stop_q;
  logic       start_edge;
  logic       stop_edge;
  logic       wr_ctrl;
  logic       loop_set;
  logic       loop_clr;
  logic       en_d1;
  logic       en_d2;
  run_state_t run_state;

  // previous level of the global controls
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      start_q <= 1'b0;
      stop_q  <= 1'b0;
    end else begin
      start_q <= core_global_start;
      stop_q  <= core_global_stop;
    end
  end

  assign start_edge = core_global_start & ~start_q;
  assign stop_edge  = core_global_stop & ~stop_q;
  assign wr_ctrl    = wr_reg_decode[REG_CTRL];

  assign run_start = (wr_ctrl & wr_reg_data[CTRL_ENABLE_BIT]) | start_edge;
  assign run_done  = mr_done & mw_done;

  // set wins over clear
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      run_state <= RUN_IDLE;
    end else if (run_start) begin
      run_state <= RUN_ACTIVE;
    end else if (run_done) begin
      run_state <= RUN_IDLE;
    end
  end

  assign run_enable = (run_state == RUN_ACTIVE);

  assign loop_set = (wr_ctrl & wr_reg_data[CTRL_LOOP_BIT]) | (start_edge & (HLTP_REPEAT != 0));
  assign loop_clr = (wr_ctrl & ~wr_reg_data[CTRL_LOOP_BIT]) | stop_edge;

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      loop_enable <= 1'b0;
    end else if (loop_set) begin
      loop_enable <= 1'b1;
    end else if (loop_clr) begin
      loop_enable <= 1'b0;
    end
  end

  // late enable rises three cycles after run_enable and drops one cycle after it
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      en_d1           <= 1'b0;
      en_d2           <= 1'b0;
      run_enable_late <= 1'b0;
    end else begin
      en_d1           <= run_enable;
      en_d2           <= run_enable & en_d1;
      run_enable_late <= run_enable & en_d2;
    end
  end

  // live pointers return to zero at end of run
  always_ff @(posedge Clk) begin
    if (!rst_l || run_done) begin
      mr_ptr <= '0;
      mw_ptr <= '0;
    end else begin
      mr_ptr <= mr_ptr_update;
      mw_ptr <= mw_ptr_update;
    end
  end

endmodule

// File: source/atg_ctl_regs.sv
`timescale 1ns/1ps

module atg_ctl_regs (
  input  logic                    Clk,
  input  logic                    rst_l,
  input  atg_regs_pkg::reg_sel_t  wr_reg_decode,
  input  atg_regs_pkg::reg_word_t wr_reg_data,
  output atg_regs_pkg::reg_word_t slv_ctl,
  output atg_regs_pkg::reg_word_t mst_ctl,
  output logic                    slv_errsig_en,
  output logic                    mst_errsig_en,
  output logic                    sgl_slv_rd,
  output logic                    sgl_slv_wr,
  output logic                    disallow_excl,
  output logic                    wrs_block_rds
);
  import atg_regs_pkg::*;

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      slv_ctl <= '0;
      mst_ctl <= '0;
    end else begin
      if (wr_reg_decode[REG_SLV_CTL]) begin
        slv_ctl <= wr_reg_data;
      end
      if (wr_reg_decode[REG_MST_CTL]) begin
        mst_ctl <= wr_reg_data;
      end
    end
  end

  // error signalling enables
  assign slv_errsig_en = slv_ctl[ERRSIG_EN_BIT];
  assign mst_errsig_en = mst_ctl[ERRSIG_EN_BIT];

  // slave side controls
  assign sgl_slv_rd    = slv_ctl[16];
  assign sgl_slv_wr    = slv_ctl[17];
  assign disallow_excl = slv_ctl[18];
  assign wrs_block_rds = slv_ctl[19];

endmodule

// File: source/atg_read_mux.sv
`timescale 1ns/1ps

module atg_read_mux #(
  parameter int M_DATA_WIDTH = 32,
  parameter int S_DATA_WIDTH = 32,
  parameter int M_ID_WIDTH   = 1
) (
  input  atg_regs_pkg::reg_sel_t  rd_reg_decode,
  input  logic                    run_enable,
  input  logic                    loop_enable,
  input  atg_regs_pkg::reg_word_t slv_ctl,
  input  atg_regs_pkg::reg_word_t mst_ctl,
  input  atg_regs_pkg::reg_word_t err_sts,
  input  atg_regs_pkg::reg_word_t err_en,
  output atg_regs_pkg::reg_word_t rd_data
);
  import atg_regs_pkg::*;

  // width codes for the config word
  localparam logic [2:0] M_WIDTH_CODE = (M_DATA_WIDTH == 512) ? 3'd4 :
                                        (M_DATA_WIDTH == 256) ? 3'd3 :
                                        (M_DATA_WIDTH == 128) ? 3'd2 :
                                        (M_DATA_WIDTH == 64)  ? 3'd1 : 3'd0;
  localparam logic [2:0] S_WIDTH_CODE = (S_DATA_WIDTH == 64) ? 3'd1 : 3'd0;
  localparam logic [2:0] ID_FIELD     = 3'(M_ID_WIDTH - 1);

  reg_word_t rd_words [REG_COUNT];

  always_comb begin
    for (int i = 0; i < REG_COUNT; i++) begin
      rd_words[i] = '0;
    end
    rd_words[REG_CTRL][31:24]          = ATG_REV;
    rd_words[REG_CTRL][23:21]          = ID_FIELD;
    rd_words[REG_CTRL][CTRL_ENABLE_BIT] = run_enable;
    rd_words[REG_CTRL][CTRL_LOOP_BIT]   = loop_enable;
    rd_words[REG_SLV_CTL]              = slv_ctl & SLV_CTL_MASK;
    rd_words[REG_ERR_STS]              = err_sts;
    rd_words[REG_ERR_EN]               = err_en;
    rd_words[REG_MST_CTL]              = mst_ctl & MST_CTL_MASK;
    rd_words[REG_CONFIG][30:28]        = M_WIDTH_CODE;
    rd_words[REG_CONFIG][27:25]        = S_WIDTH_CODE;
    // full build only
    rd_words[REG_CONFIG][24]           = 1'b1;
  end

  // or of every selected word
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      if (rd_reg_decode[i]) begin
        rd_data = rd_data | rd_words[i];
      end
    end
  end

endmodule

// File: source/atg_regs_top.sv
`timescale 1ns/1ps

module atg_regs_top #(
  parameter int HLTP_REPEAT  = 1,
  parameter int M_DATA_WIDTH = 64,
  parameter int S_DATA_WIDTH = 32,
  parameter int M_ID_WIDTH   = 4
) (
  input  logic                    Clk,
  input  logic                    rst_l,
  input  atg_regs_pkg::reg_sel_t  wr_reg_decode,
  input  atg_regs_pkg::reg_word_t wr_reg_data,
  input  atg_regs_pkg::reg_sel_t  rd_reg_decode,
  output atg_regs_pkg::reg_word_t rd_reg_data,
  input  logic                    core_global_start,
  input  logic                    core_global_stop,
  input  logic                    mr_done,
  input  logic                    mw_done,
  input  atg_regs_pkg::cmd_ptr_t  mr_ptr_update,
  input  atg_regs_pkg::cmd_ptr_t  mw_ptr_update,
  input  atg_regs_pkg::err_half_t err_new_slv,
  input  logic                    mr_unexp,
  input  logic                    b_resp_unexp,
  input  logic                    b_resp_bad,
  input  logic                    mr_resp_bad,
  input  logic                    mr_bad_last,
  output logic                    run_enable,
  output logic                    run_enable_late,
  output logic                    loop_enable,
  output atg_regs_pkg::cmd_ptr_t  mr_ptr,
  output atg_regs_pkg::cmd_ptr_t  mw_ptr,
  output logic                    sgl_slv_rd,
  output logic                    sgl_slv_wr,
  output logic                    disallow_excl,
  output logic                    wrs_block_rds,
  output logic                    err_out,
  output logic                    irq_out
);
  import atg_regs_pkg::*;

  logic      run_start;
  logic      run_done;
  logic      slv_errsig_en;
  logic      mst_errsig_en;
  reg_word_t slv_ctl;
  reg_word_t mst_ctl;
  reg_word_t err_sts;
  reg_word_t err_en;

  atg_run_ctl #(
    .HLTP_REPEAT (HLTP_REPEAT)
  ) atg_run_ctl_inst (
    .Clk               (Clk),
    .rst_l             (rst_l),
    .wr_reg_decode     (wr_reg_decode),
    .wr_reg_data       (wr_reg_data),
    .core_global_start (core_global_start),
    .core_global_stop  (core_global_stop),
    .mr_done           (mr_done),
    .mw_done           (mw_done),
    .mr_ptr_update     (mr_ptr_update),
    .mw_ptr_update     (mw_ptr_update),
    .run_start         (run_start),
    .run_done          (run_done),
    .run_enable        (run_enable),
    .run_enable_late   (run_enable_late),
    .loop_enable       (loop_enable),
    .mr_ptr            (mr_ptr),
    .mw_ptr            (mw_ptr)
  );

  atg_err_status atg_err_status_inst (
    .Clk           (Clk),
    .rst_l         (rst_l),
    .wr_reg_decode (wr_reg_decode),
    .wr_reg_data   (wr_reg_data),
    .run_start     (run_start),
    .run_done      (run_done),
    .slv_errsig_en (slv_errsig_en),
    .mst_errsig_en (mst_errsig_en),
    .err_new_slv   (err_new_slv),
    .mr_unexp      (mr_unexp),
    .b_resp_unexp  (b_resp_unexp),
    .b_resp_bad    (b_resp_bad),
    .mr_resp_bad   (mr_resp_bad),
    .mr_bad_last   (mr_bad_last),
    .err_sts       (err_sts),
    .err_en        (err_en),
    .err_out       (err_out),
    .irq_out       (irq_out)
  );

  atg_ctl_regs atg_ctl_regs_inst (
    .Clk           (Clk),
    .rst_l         (rst_l),
    .wr_reg_decode (wr_reg_decode),
    .wr_reg_data   (wr_reg_data),
    .slv_ctl       (slv_ctl),
    .mst_ctl       (mst_ctl),
    .slv_errsig_en (slv_errsig_en),
    .mst_errsig_en (mst_errsig_en),
    .sgl_slv_rd    (sgl_slv_rd),
    .sgl_slv_wr    (sgl_slv_wr),
    .disallow_excl (disallow_excl),
    .wrs_block_rds (wrs_block_rds)
  );

  atg_read_mux #(
    .M_DATA_WIDTH (M_DATA_WIDTH),
    .S_DATA_WIDTH (S_DATA_WIDTH),
    .M_ID_WIDTH   (M_ID_WIDTH)
  ) atg_read_mux_inst (
    .rd_reg_decode (rd_reg_decode),
    .run_enable    (run_enable),
    .loop_enable   (loop_enable),
    .slv_ctl       (slv_ctl),
    .mst_ctl       (mst_ctl),
    .err_sts       (err_sts),
    .err_en        (err_en),
    .rd_data       (rd_reg_data)
  );

endmodule

// File: status/atg_err_status.sv
`timescale 1ns/1ps

module atg_err_status (
  input  logic                    Clk,
  input  logic                    rst_l,
  input  atg_regs_pkg::reg_sel_t  wr_reg_decode,
  input  atg_regs_pkg::reg_word_t wr_reg_data,
  input  logic                    run_start,
  input  logic                    run_done,
  input  logic                    slv_errsig_en,
  input  logic                    mst_errsig_en,
  input  atg_regs_pkg::err_half_t err_new_slv,
  input  logic                    mr_unexp,
  input  logic                    b_resp_unexp,
  input  logic                    b_resp_bad,
  input  logic                    mr_resp_bad,
  input  logic                    mr_bad_last,
  output atg_regs_pkg::reg_word_t err_sts,
  output atg_regs_pkg::reg_word_t err_en,
  output logic                    err_out,
  output logic                    irq_out
);
  import atg_regs_pkg::*;

  err_half_t err_new_mst;
  reg_word_t err_new;
  reg_word_t sts_kept;
  logic      err_detect;

  // master half holds run complete on top and response errors at 20:16
  assign err_new_mst = {run_done, 10'b0, mr_unexp, b_resp_unexp, b_resp_bad,
                        mr_resp_bad, mr_bad_last};
  assign err_new     = {err_new_mst, err_new_slv};

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      err_en <= ERR_EN_RESET;
    end else if (wr_reg_decode[REG_ERR_EN]) begin
      err_en <= wr_reg_data;
    end
  end

  // write one to clear
  assign sts_kept = wr_reg_decode[REG_ERR_STS] ? (err_sts & ~wr_reg_data) : err_sts;

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      err_sts <= '0;
    end else if (run_start) begin
      // fresh run starts from a clean status
      err_sts <= '0;
    end else begin
      err_sts <= sts_kept | (err_en & err_new);
    end
  end

  assign err_detect = (slv_errsig_en & (|err_sts[15:0])) |
                      (mst_errsig_en & (|err_sts[DONE_ERR_BIT-1:16]));

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      err_out <= 1'b0;
    end else begin
      err_out <= err_detect;
    end
  end

  assign irq_out = err_sts[DONE_ERR_BIT];

endmodule

// File: testbench/atg_regs_chk.sv
`timescale 1ns/1ps

module atg_regs_chk (
  input logic                    Clk,
  input logic                    rst_l,
  input logic                    err_out,
  input atg_regs_pkg::reg_word_t err_sts,
  input logic                    run_enable,
  input logic                    run_enable_late,
  input logic                    mr_done,
  input logic                    mw_done,
  input atg_regs_pkg::cmd_ptr_t  mr_ptr,
  input atg_regs_pkg::cmd_ptr_t  mw_ptr
);

  int assert_errors = 0;

  // err_out is registered from a non-zero status
  err_from_status: assert property (@(posedge Clk) disable iff (!rst_l)
    err_out |-> $past(err_sts != '0))
    else begin
      assert_errors++;
      $error("err_out high without status in the previous cycle");
    end

  // late enable lags, so it only needs run_enable one cycle back
  late_needs_enable: assert property (@(posedge Clk) disable iff (!rst_l)
    run_enable_late |-> $past(run_enable))
    else begin
      assert_errors++;
      $error("run_enable_late high without run_enable");
    end

  ptr_zero_after_done: assert property (@(posedge Clk) disable iff (!rst_l)
    (mr_done && mw_done) |=> (mr_ptr == '0 && mw_ptr == '0))
    else begin
      assert_errors++;
      $error("command pointers not zero after run done");
    end

endmodule

bind atg_regs_top atg_regs_chk atg_regs_chk_inst (
  .Clk             (Clk),
  .rst_l           (rst_l),
  .err_out         (err_out),
  .err_sts         (err_sts),
  .run_enable      (run_enable),
  .run_enable_late (run_enable_late),
  .mr_done         (mr_done),
  .mw_done         (mw_done),
  .mr_ptr          (mr_ptr),
  .mw_ptr          (mw_ptr)
);

// File: testbench/tb_atg_regs.sv
`timescale 1ns/1ps

module tb_atg_regs;
  import atg_regs_pkg::*;

  localparam int HLTP_REPEAT  = 1;
  localparam int M_DATA_WIDTH = 64;
  localparam int S_DATA_WIDTH = 32;
  localparam int M_ID_WIDTH   = 4;
  localparam int TIMEOUT      = 50;

  // width codes count doublings above 32 bits
  localparam logic [2:0] M_CODE = 3'($clog2(M_DATA_WIDTH / 32));
  localparam logic [2:0] S_CODE = 3'($clog2(S_DATA_WIDTH / 32));
  localparam reg_word_t  EXP_CONFIG = {1'b0, M_CODE, S_CODE, 1'b1, 24'h0};

  logic      Clk;
  logic      rst_l;
  reg_sel_t  wr_reg_decode;
  reg_word_t wr_reg_data;
  reg_sel_t  rd_reg_decode;
  reg_word_t rd_reg_data;
  logic      core_global_start;
  logic      core_global_stop;
  logic      mr_done;
  logic      mw_done;
  cmd_ptr_t  mr_ptr_update;
  cmd_ptr_t  mw_ptr_update;
  err_half_t err_new_slv;
  logic      mr_unexp;
  logic      b_resp_unexp;
  logic      b_resp_bad;
  logic      mr_resp_bad;
  logic      mr_bad_last;
  logic      run_enable;
  logic      run_enable_late;
  logic      loop_enable;
  cmd_ptr_t  mr_ptr;
  cmd_ptr_t  mw_ptr;
  logic      sgl_slv_rd;
  logic      sgl_slv_wr;
  logic      disallow_excl;
  logic      wrs_block_rds;
  logic      err_out;
  logic      irq_out;

  // reference model state
  reg_word_t   m_slv;
  reg_word_t   m_mst;
  reg_word_t   m_en;
  reg_word_t   m_sts;
  logic        m_run;
  logic        m_loop;
  logic        m_err_out;
  logic        m_start_q;
  logic        m_stop_q;
  logic [2:0]  m_hist;
  cmd_ptr_t    m_mr_ptr;
  cmd_ptr_t    m_mw_ptr;
  logic [31:0] lfsr = 32'h2860;
  string       test_name;

  atg_regs_top #(
    .HLTP_REPEAT  (HLTP_REPEAT),
    .M_DATA_WIDTH (M_DATA_WIDTH),
    .S_DATA_WIDTH (S_DATA_WIDTH),
    .M_ID_WIDTH   (M_ID_WIDTH)
  ) atg_regs_top_inst (.*);

  initial begin
    Clk = 1'b0;
    forever #2 Clk = ~Clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic reg_word_t model_read(input int idx);
    case (idx)
      REG_CTRL:    return {ATG_REV, 3'(M_ID_WIDTH - 1), m_run, m_loop, 19'h0};
      REG_SLV_CTL: return m_slv & 32'h000F_FFFF;
      REG_ERR_STS: return m_sts;
      REG_ERR_EN:  return m_en;
      REG_MST_CTL: return m_mst & 32'h0000_FFFF;
      REG_CONFIG:  return EXP_CONFIG;
      default:     return '0;
    endcase
  endfunction

  // advance the model with the driven inputs, then one clock, then compare outputs
  task automatic tick();
    logic      start_edge;
    logic      stop_edge;
    logic      run_start;
    logic      run_done;
    logic      wr0;
    reg_word_t err_new;
    reg_word_t sts_next;
    start_edge = core_global_start & ~m_start_q;
    stop_edge  = core_global_stop & ~m_stop_q;
    wr0        = wr_reg_decode[REG_CTRL];
    run_start  = (wr0 & wr_reg_data[20]) | start_edge;
    run_done   = mr_done & mw_done;
    err_new    = {run_done, 10'h0, mr_unexp, b_resp_unexp, b_resp_bad, mr_resp_bad,
                  mr_bad_last, err_new_slv};
    sts_next = m_sts;
    if (wr_reg_decode[REG_ERR_STS]) begin
      sts_next = sts_next & ~wr_reg_data;
    end
    sts_next = sts_next | (m_en & err_new);
    if (run_start) begin
      sts_next = '0;
    end
    m_err_out = (m_slv[15] && m_sts[15:0] != 0) || (m_mst[15] && m_sts[30:16] != 0);
    m_hist    = {m_hist[1:0], m_run};
    if (run_start) begin
      m_run = 1'b1;
    end else if (run_done) begin
      m_run = 1'b0;
    end
    if ((wr0 & wr_reg_data[19]) | (start_edge & (HLTP_REPEAT != 0))) begin
      m_loop = 1'b1;
    end else if ((wr0 & ~wr_reg_data[19]) | stop_edge) begin
      m_loop = 1'b0;
    end
    m_mr_ptr = run_done ? '0 : mr_ptr_update;
    m_mw_ptr = run_done ? '0 : mw_ptr_update;
    m_sts    = sts_next;
    if (wr_reg_decode[REG_ERR_EN]) m_en = wr_reg_data;
    if (wr_reg_decode[REG_SLV_CTL]) m_slv = wr_reg_data;
    if (wr_reg_decode[REG_MST_CTL]) m_mst = wr_reg_data;
    m_start_q = core_global_start;
    m_stop_q  = core_global_stop;
    @(posedge Clk);
    #1;
    check_val("run_enable", m_run, run_enable);
    check_val("run_enable_late", &m_hist, run_enable_late);
    check_val("loop_enable", m_loop, loop_enable);
    check_val("mr_ptr", m_mr_ptr, mr_ptr);
    check_val("mw_ptr", m_mw_ptr, mw_ptr);
    check_val("err_out", m_err_out, err_out);
    check_val("irq_out", m_sts[31], irq_out);
    check_val("slave controls", m_slv[19:16],
              {wrs_block_rds, disallow_excl, sgl_slv_wr, sgl_slv_rd});
    check_val("assertions", 0, atg_regs_top_inst.atg_regs_chk_inst.assert_errors);
  endtask

  task automatic write_reg(input int idx, input reg_word_t data);
    wr_reg_decode = reg_sel_t'(1) << idx;
    wr_reg_data   = data;
    tick();
    wr_reg_decode = '0;
  endtask

  task automatic read_check(input int idx);
    rd_reg_decode = reg_sel_t'(1) << idx;
    #1;
    check_val($sformatf("read reg %0d", idx), model_read(idx), rd_reg_data);
    rd_reg_decode = '0;
    tick();
  endtask

  task automatic pulse_done();
    mr_done = 1'b1;
    mw_done = 1'b1;
    tick();
    mr_done = 1'b0;
    mw_done = 1'b0;
  endtask

  // counts cycles from the run_enable rise
  task automatic wait_late();
    int n;
    n = 0;
    while (!run_enable_late && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (!run_enable_late) begin
      $display("timeout waiting for run_enable_late to rise");
      $display("Something failed");
      $fatal(1);
    end else begin
      check_val("late enable delay", 3, n);
    end
  endtask

  initial begin
    rst_l             = 1'b0;
    wr_reg_decode     = '0;
    wr_reg_data       = '0;
    rd_reg_decode     = '0;
    core_global_start = 1'b0;
    core_global_stop  = 1'b0;
    mr_done           = 1'b0;
    mw_done           = 1'b0;
    mr_ptr_update     = '0;
    mw_ptr_update     = '0;
    err_new_slv       = '0;
    {mr_unexp, b_resp_unexp, b_resp_bad, mr_resp_bad, mr_bad_last} = 5'h0;
    m_slv = '0;
    m_mst = '0;
    m_en  = 32'h8000_0000;
    m_sts = '0;
    {m_run, m_loop, m_err_out, m_start_q, m_stop_q} = 5'h0;
    m_hist   = '0;
    m_mr_ptr = '0;
    m_mw_ptr = '0;
    repeat (16) @(posedge Clk);
    #1;
    rst_l = 1'b1;

    test_name = "reset";
    for (int i = 0; i < REG_COUNT; i++) begin
      read_check(i);
    end

    test_name = "ctl_regs";
    repeat (8) begin
      write_reg(REG_SLV_CTL, rand_bits(32));
      write_reg(REG_MST_CTL, rand_bits(32));
      read_check(REG_SLV_CTL);
      read_check(REG_MST_CTL);
    end

    test_name = "run";
    write_reg(REG_CTRL, 32'h0010_0000);
    wait_late();
    repeat (6) begin
      mr_ptr_update = cmd_ptr_t'(rand_bits(PTR_W));
      mw_ptr_update = cmd_ptr_t'(rand_bits(PTR_W));
      tick();
    end
    pulse_done();
    tick();
    check_val("irq after done", 1, irq_out);
    read_check(REG_ERR_STS);
    read_check(REG_CTRL);

    // done arrives mid-hold, so a second start would show
    test_name = "global";
    core_global_start = 1'b1;
    repeat (3) tick();
    pulse_done();
    repeat (6) tick();
    check_val("single start", 0, run_enable);
    check_val("loop set by start", 1, loop_enable);
    core_global_start = 1'b0;
    tick();
    core_global_stop = 1'b1;
    repeat (3) tick();
    check_val("loop cleared by stop", 0, loop_enable);
    core_global_stop = 1'b0;
    write_reg(REG_CTRL, 32'h0008_0000);
    read_check(REG_CTRL);
    write_reg(REG_CTRL, 32'h0);
    read_check(REG_CTRL);

    test_name = "errors";
    write_reg(REG_ERR_EN, rand_bits(32));
    write_reg(REG_SLV_CTL, rand_bits(32) | 32'h8000);
    write_reg(REG_MST_CTL, rand_bits(32));
    repeat (20) begin
      err_new_slv = err_half_t'(rand_bits(16) & rand_bits(16));
      {mr_unexp, b_resp_unexp, b_resp_bad, mr_resp_bad, mr_bad_last} =
        5'(rand_bits(5) & rand_bits(5));
      read_check(REG_ERR_STS);
    end
    err_new_slv = '0;
    {mr_unexp, b_resp_unexp, b_resp_bad, mr_resp_bad, mr_bad_last} = 5'h0;
    tick();
    write_reg(REG_ERR_STS, rand_bits(32));
    read_check(REG_ERR_STS);
    write_reg(REG_CTRL, 32'h0010_0000);
    read_check(REG_ERR_STS);
    pulse_done();
    tick();

    if (atg_regs_top_inst.atg_regs_chk_inst.assert_errors != 0) begin
      $display("bound assertions reported a failure");
      $display("Something failed");
      $fatal(1);
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: vlog.f
common/atg_regs_pkg.sv
control/atg_run_ctl.sv
status/atg_err_status.sv
source/atg_ctl_regs.sv
source/atg_read_mux.sv
source/atg_regs_top.sv
testbench/atg_regs_chk.sv
testbench/tb_atg_regs.sv
